// ==== verilog/tart_params.svh ====
`ifndef TART_PARAMS_SVH
`define TART_PARAMS_SVH

// ------------------------------
// Array geometry
// ------------------------------
`define TART_ANTENNAE    4   // Receiver channels, one bit each
`define TART_ACCUM_BITS  16  // Width of one agreement counter
`define TART_BLOCK_LEN   32  // Samples per correlation block

// ------------------------------
// Raw-data buffer and host bus
// ------------------------------
`define TART_FIFO_DEPTH  16  // Power of two, pointers wrap naturally
`define TART_BUS_BITS    8   // Host data width
`define TART_ADR_BITS    3   // Host register address width

`endif

// ==== verilog/tart_pkg.sv ====
`default_nettype none

`include "tart_params.svh"

package tart_pkg;

    // Antenna pairs, (0,1) first and (N-2,N-1) last
    localparam int NUM_PAIRS = `TART_ANTENNAE * (`TART_ANTENNAE - 1) / 2;

    typedef logic [`TART_ACCUM_BITS-1:0] vis_t;  // One agreement count

    // ------------------------------
    // Data path
    // ------------------------------
    typedef struct packed {
        logic                      valid;  // High for one cycle per new sample
        logic [`TART_ANTENNAE-1:0] ant;    // Bit per antenna, antenna 0 at LSB
    } sample_t;

    // ------------------------------
    // Host bus, strobe in and ack out
    // ------------------------------
    typedef struct packed {
        logic                      stb;
        logic                      we;
        logic [`TART_ADR_BITS-1:0] adr;
        logic [`TART_BUS_BITS-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                      ack;    // One cycle after stb
        logic [`TART_BUS_BITS-1:0] rdata;  // Valid with ack
    } bus_rsp_t;

    // CTRL register, cap_en at bit 3 down to cor_en at bit 0
    typedef struct packed {
        logic cap_en;
        logic fake_en;
        logic acq_en;
        logic cor_en;
    } ctrl_t;

    // Register map
    typedef enum logic [`TART_ADR_BITS-1:0] {
        CTRL      = 3'd0,
        STATUS    = 3'd1,
        VIS_IDX   = 3'd2,
        VIS_LO    = 3'd3,
        VIS_HI    = 3'd4,
        ACQ_DATA  = 3'd5,
        ACQ_LEVEL = 3'd6   // 7 left unmapped
    } reg_addr_e;

    typedef enum logic {
        SRC_LIVE = 1'b0,  // Receiver bits
        SRC_FAKE = 1'b1   // LFSR bits
    } src_mode_e;

endpackage

`default_nettype wire

// ==== verilog/tart_capture.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tart_params.svh"

module tart_capture (
    input  wire                      clock_b,
    input  wire                      arst_n_i,
    input  wire [`TART_ANTENNAE-1:0] antenna_i,     // Already aligned to strobe
    input  wire                      sample_stb_i,
    input  wire tart_pkg::ctrl_t     ctrl_i,
    output tart_pkg::sample_t        sample_o
);
    import tart_pkg::*;

    localparam logic [15:0] LFSR_SEED = 16'hACE1;

    src_mode_e                 src_mode;
    logic                      accept;    // Strobe taken this cycle
    logic                      lfsr_fb;
    logic [15:0]               lfsr_q;
    logic                      valid_q;
    logic [`TART_ANTENNAE-1:0] ant_q;

    assign src_mode = ctrl_i.fake_en ? SRC_FAKE : SRC_LIVE;
    assign accept   = sample_stb_i && ctrl_i.cap_en;

    // ------------------------------
    // Fake source
    // ------------------------------
    // Fibonacci form, taps 16 14 13 11, shifting toward the LSB
    assign lfsr_fb = lfsr_q[0] ^ lfsr_q[2] ^ lfsr_q[3] ^ lfsr_q[5];

    always_ff @(posedge clock_b or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lfsr_q <= LFSR_SEED;
        end else if (accept && src_mode == SRC_FAKE) begin
            lfsr_q <= {lfsr_fb, lfsr_q[15:1]};  // Step after its bits are taken
        end
    end

    // ------------------------------
    // Sample register
    // ------------------------------
    always_ff @(posedge clock_b or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;  // One-cycle flag per strobe
        end
    end

    always_ff @(posedge clock_b) begin
        if (accept) begin
            if (src_mode == SRC_FAKE) begin
                ant_q <= lfsr_q[`TART_ANTENNAE-1:0];  // Current state, low bits
            end else begin
                ant_q <= antenna_i;
            end
        end
    end

    assign sample_o = '{valid: valid_q, ant: ant_q};

endmodule

`default_nettype wire

// ==== verilog/tart_correlator.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tart_params.svh"

module tart_correlator (
    input  wire                      clock_b,
    input  wire                      arst_n_i,
    input  wire tart_pkg::sample_t   sample_i,
    input  wire                      cor_en_i,
    input  wire                      stat_rd_i,      // STATUS read, clears block_ready
    input  wire [2:0]                vis_idx_i,
    output tart_pkg::vis_t           vis_o,
    output logic [3:0]               block_cnt_o,
    output logic                     block_ready_o
);
    import tart_pkg::*;

    localparam int N        = `TART_ANTENNAE;
    localparam int BLK      = `TART_BLOCK_LEN;
    localparam int CNT_BITS = $clog2(BLK);

    logic [NUM_PAIRS-1:0] agree;         // Pair bits equal
    logic                 take;          // Sample accumulated this cycle
    logic                 last;          // Closes the block
    logic [CNT_BITS-1:0]  smp_cnt_q;
    vis_t                 acc_q  [NUM_PAIRS];
    vis_t                 bank_q [NUM_PAIRS];
    logic [3:0]           block_cnt_q;
    logic                 block_ready_q;

    // ------------------------------
    // Pair comparators
    // ------------------------------
    // Row-major over i<j, so index 0 is (0,1) and index 5 is (2,3)
    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = i + 1; j < N; j++) begin : g_col
            localparam int P = i * (2 * N - i - 1) / 2 + (j - i - 1);
            assign agree[P] = sample_i.ant[i] ~^ sample_i.ant[j];
        end
    end

    assign take = sample_i.valid && cor_en_i;
    assign last = take && (smp_cnt_q == CNT_BITS'(BLK - 1));

    // ------------------------------
    // Accumulators and block control
    // ------------------------------
    always_ff @(posedge clock_b or negedge arst_n_i) begin
        if (!arst_n_i) begin
            smp_cnt_q     <= '0;
            block_cnt_q   <= '0;
            block_ready_q <= 1'b0;
            for (int p = 0; p < NUM_PAIRS; p++) begin
                acc_q[p] <= '0;
            end
        end else begin
            if (take) begin
                smp_cnt_q <= smp_cnt_q + 1'b1;  // Wraps at block length
                for (int p = 0; p < NUM_PAIRS; p++) begin
                    if (last) begin
                        acc_q[p] <= '0;  // Fresh block
                    end else begin
                        acc_q[p] <= acc_q[p] + vis_t'(agree[p]);
                    end
                end
            end
            if (last) begin
                block_cnt_q   <= block_cnt_q + 1'b1;
                block_ready_q <= 1'b1;  // Set wins over a same-cycle read
            end else if (stat_rd_i) begin
                block_ready_q <= 1'b0;
            end
        end
    end

    // Read bank, final count includes the closing sample
    always_ff @(posedge clock_b) begin
        if (last) begin
            for (int p = 0; p < NUM_PAIRS; p++) begin
                bank_q[p] <= acc_q[p] + vis_t'(agree[p]);
            end
        end
    end

    // ------------------------------
    // Read-back
    // ------------------------------
    always_comb begin
        if (int'(vis_idx_i) < NUM_PAIRS) begin
            vis_o = bank_q[vis_idx_i];
        end else begin
            vis_o = '0;  // Indexes 6 and 7
        end
    end

    assign block_cnt_o   = block_cnt_q;
    assign block_ready_o = block_ready_q;

    // Count can never pass the samples seen in one block
    for (genvar p = 0; p < NUM_PAIRS; p++) begin : g_chk
        a_acc_bound : assert property (
            @(posedge clock_b) disable iff (!arst_n_i)
            acc_q[p] <= vis_t'(BLK)
        );
    end

endmodule

`default_nettype wire

// ==== verilog/tart_acquire.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tart_params.svh"

module tart_acquire (
    input  wire                               clock_b,
    input  wire                               arst_n_i,
    input  wire tart_pkg::sample_t            sample_i,
    input  wire                               acq_en_i,
    input  wire                               pop_i,
    input  wire                               clr_flags_i,
    output logic [`TART_ANTENNAE-1:0]         head_o,       // Zero when empty
    output logic [$clog2(`TART_FIFO_DEPTH):0] level_o,
    output logic                              empty_o,
    output logic                              overflow_o,
    output logic                              underflow_o
);
    localparam int DEPTH    = `TART_FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    logic [`TART_ANTENNAE-1:0] mem_q [DEPTH];
    logic [PTR_BITS-1:0]       wr_ptr_q;
    logic [PTR_BITS-1:0]       rd_ptr_q;
    logic [PTR_BITS:0]         level_q;
    logic                      full;
    logic                      empty;
    logic                      push_req;
    logic                      push;
    logic                      pop;

    assign full     = (level_q == (PTR_BITS + 1)'(DEPTH));
    assign empty    = (level_q == '0);
    assign push_req = sample_i.valid && acq_en_i;
    assign push     = push_req && !full;   // Full FIFO drops the word
    assign pop      = pop_i && !empty;

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge clock_b) begin
        if (push) begin
            mem_q[wr_ptr_q] <= sample_i.ant;
        end
    end

    // ------------------------------
    // Pointers, level and flags
    // ------------------------------
    always_ff @(posedge clock_b or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            level_q     <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;  // Both or neither
            endcase
            // Sticky until a CTRL write, a new event wins
            if (push_req && full) begin
                overflow_o <= 1'b1;
            end else if (clr_flags_i) begin
                overflow_o <= 1'b0;
            end
            if (pop_i && empty) begin
                underflow_o <= 1'b1;
            end else if (clr_flags_i) begin
                underflow_o <= 1'b0;
            end
        end
    end

    assign head_o  = empty ? '0 : mem_q[rd_ptr_q];
    assign level_o = level_q;
    assign empty_o = empty;

    a_level_bound : assert property (
        @(posedge clock_b) disable iff (!arst_n_i)
        level_q <= (PTR_BITS + 1)'(DEPTH)
    );

endmodule

`default_nettype wire

// ==== verilog/tart_control.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tart_params.svh"

module tart_control (
    input  wire                               clock_b,
    input  wire                               arst_n_i,
    input  wire tart_pkg::bus_req_t           bus_req_i,
    output tart_pkg::bus_rsp_t                bus_rsp_o,
    output tart_pkg::ctrl_t                   ctrl_o,
    output logic [2:0]                        vis_idx_o,
    output logic                              stat_rd_o,    // STATUS read this cycle
    output logic                              acq_pop_o,    // ACQ_DATA read this cycle
    output logic                              clr_flags_o,  // CTRL write this cycle
    input  wire tart_pkg::vis_t               vis_i,
    input  wire [3:0]                         block_cnt_i,
    input  wire                               block_ready_i,
    input  wire [`TART_ANTENNAE-1:0]          head_i,
    input  wire [$clog2(`TART_FIFO_DEPTH):0]  level_i,
    input  wire                               empty_i,
    input  wire                               overflow_i,
    input  wire                               underflow_i
);
    import tart_pkg::*;

    localparam int BW  = `TART_BUS_BITS;
    localparam int LVB = $clog2(`TART_FIFO_DEPTH) + 1;

    reg_addr_e       adr;
    logic            rd_stb;
    logic            wr_stb;
    logic [BW-1:0]   status;
    logic [BW-1:0]   rdata_d;
    ctrl_t           ctrl_q;
    logic [2:0]      vis_idx_q;
    logic            ack_q;
    logic [BW-1:0]   rdata_q;

    assign adr    = reg_addr_e'(bus_req_i.adr);
    assign rd_stb = bus_req_i.stb && !bus_req_i.we;
    assign wr_stb = bus_req_i.stb && bus_req_i.we;

    // Side effects land on the strobe edge, same as the read capture
    assign stat_rd_o   = rd_stb && (adr == STATUS);
    assign acq_pop_o   = rd_stb && (adr == ACQ_DATA);
    assign clr_flags_o = wr_stb && (adr == CTRL);

    // ------------------------------
    // Writable registers
    // ------------------------------
    always_ff @(posedge clock_b or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q    <= '0;
            vis_idx_q <= '0;
        end else if (wr_stb) begin
            case (adr)
                CTRL:    ctrl_q    <= ctrl_t'(bus_req_i.wdata[$bits(ctrl_t)-1:0]);
                VIS_IDX: vis_idx_q <= bus_req_i.wdata[2:0];
                default: ;  // Read-only and unmapped, dropped
            endcase
        end
    end

    // ------------------------------
    // Read mux
    // ------------------------------
    assign status = {overflow_i, underflow_i, empty_i, block_ready_i, block_cnt_i};

    always_comb begin
        case (adr)
            CTRL:      rdata_d = {{(BW - $bits(ctrl_t)){1'b0}}, ctrl_q};
            STATUS:    rdata_d = status;
            VIS_IDX:   rdata_d = {{(BW - 3){1'b0}}, vis_idx_q};
            VIS_LO:    rdata_d = vis_i[BW-1:0];
            VIS_HI:    rdata_d = vis_i[2*BW-1:BW];
            ACQ_DATA:  rdata_d = {{(BW - `TART_ANTENNAE){1'b0}}, head_i};  // Pre-pop head
            ACQ_LEVEL: rdata_d = {{(BW - LVB){1'b0}}, level_i};
            default:   rdata_d = '0;  // Address 7
        endcase
    end

    // ------------------------------
    // Response
    // ------------------------------
    always_ff @(posedge clock_b or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req_i.stb;  // Every strobe answered, no stall
        end
    end

    always_ff @(posedge clock_b) begin
        if (rd_stb) begin
            rdata_q <= rdata_d;
        end
    end

    assign bus_rsp_o = '{ack: ack_q, rdata: rdata_q};
    assign ctrl_o    = ctrl_q;
    assign vis_idx_o = vis_idx_q;

    a_ack_after_stb : assert property (
        @(posedge clock_b) disable iff (!arst_n_i)
        bus_rsp_o.ack |-> $past(bus_req_i.stb)
    );

endmodule

`default_nettype wire

// ==== verilog/tart_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tart_params.svh"

module tart_top (
    input  wire                      clock_b,
    input  wire                      arst_n_i,
    input  wire [`TART_ANTENNAE-1:0] antenna_i,
    input  wire                      sample_stb_i,
    input  wire tart_pkg::bus_req_t  bus_req_i,
    output tart_pkg::bus_rsp_t       bus_rsp_o
);
    import tart_pkg::*;

    // ------------------------------
    // Internal wiring
    // ------------------------------
    ctrl_t                            ctrl;
    sample_t                          sample;       // Feeds both consumers
    vis_t                             vis;
    logic [2:0]                       vis_idx;
    logic                             stat_rd;
    logic                             acq_pop;
    logic                             clr_flags;
    logic [3:0]                       block_cnt;
    logic                             block_ready;
    logic [`TART_ANTENNAE-1:0]        head;
    logic [$clog2(`TART_FIFO_DEPTH):0] level;
    logic                             empty;
    logic                             overflow;
    logic                             underflow;

    tart_capture tart_capture_inst (
        .clock_b      (clock_b),
        .arst_n_i     (arst_n_i),
        .antenna_i    (antenna_i),
        .sample_stb_i (sample_stb_i),
        .ctrl_i       (ctrl),
        .sample_o     (sample)
    );

    tart_correlator tart_correlator_inst (
        .clock_b       (clock_b),
        .arst_n_i      (arst_n_i),
        .sample_i      (sample),
        .cor_en_i      (ctrl.cor_en),
        .stat_rd_i     (stat_rd),
        .vis_idx_i     (vis_idx),
        .vis_o         (vis),
        .block_cnt_o   (block_cnt),
        .block_ready_o (block_ready)
    );

    tart_acquire tart_acquire_inst (
        .clock_b     (clock_b),
        .arst_n_i    (arst_n_i),
        .sample_i    (sample),
        .acq_en_i    (ctrl.acq_en),
        .pop_i       (acq_pop),
        .clr_flags_i (clr_flags),
        .head_o      (head),
        .level_o     (level),
        .empty_o     (empty),
        .overflow_o  (overflow),
        .underflow_o (underflow)
    );

    // Host side, merges both result paths
    tart_control tart_control_inst (
        .clock_b       (clock_b),
        .arst_n_i      (arst_n_i),
        .bus_req_i     (bus_req_i),
        .bus_rsp_o     (bus_rsp_o),
        .ctrl_o        (ctrl),
        .vis_idx_o     (vis_idx),
        .stat_rd_o     (stat_rd),
        .acq_pop_o     (acq_pop),
        .clr_flags_o   (clr_flags),
        .vis_i         (vis),
        .block_cnt_i   (block_cnt),
        .block_ready_i (block_ready),
        .head_i        (head),
        .level_i       (level),
        .empty_i       (empty),
        .overflow_i    (overflow),
        .underflow_i   (underflow)
    );

endmodule

`default_nettype wire

// ==== tests/tb_tart.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tart_params.svh"

module tb_tart;
    import tart_pkg::*;

    localparam int unsigned SEED = 32'h7681_152a;
    localparam int N     = `TART_ANTENNAE;
    localparam int BLK   = `TART_BLOCK_LEN;
    localparam int DEPTH = `TART_FIFO_DEPTH;
    // Two blocks at up to 4 cycles a sample, 20 raw strobes, ~60 bus accesses
    // at 2 cycles each; under 1000 cycles in all, so 5000 leaves wide margin
    localparam int MAX_CYCLES = 5000;

    logic     clock_b;
    logic     arst_n_i;
    logic [N-1:0] antenna_i;
    logic     sample_stb_i;
    bus_req_t bus_req_i;
    bus_rsp_t bus_rsp_o;

    int errors = 0;
    int checks = 0;
    int cycle_cnt = 0;

    logic stb_seen = 1'b0;  // stb taken at the last rising edge

    // ------------------------------
    // Reference model state
    // ------------------------------
    logic [15:0]  lfsr_m;                // Fake source
    logic         m_cap;
    logic         m_fake;
    logic         m_acq;
    logic         m_cor;
    int           pair_acc [NUM_PAIRS];  // Running block counts
    int           blk_smp;
    logic [15:0]  exp_bank [NUM_PAIRS];  // Last closed block
    logic [3:0]   exp_blk;
    logic         exp_ready;
    logic         exp_ovf;
    logic         exp_unf;
    logic [N-1:0] fifo_m [$];

    tart_top tart_top_inst (
        .clock_b      (clock_b),
        .arst_n_i     (arst_n_i),
        .antenna_i    (antenna_i),
        .sample_stb_i (sample_stb_i),
        .bus_req_i    (bus_req_i),
        .bus_rsp_o    (bus_rsp_o)
    );

    initial begin
        clock_b = 1'b0;
        forever #5 clock_b = ~clock_b;  // 10 ns period
    end

    // Run limit
    always @(posedge clock_b) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("checks %0d errors %0d", checks, errors + 1);
            $display("test failed");
            $finish;
        end
    end

    // ------------------------------
    // Bus protocol monitor
    // ------------------------------
    // ack follows each strobe by one cycle and is low otherwise
    always @(negedge clock_b) begin
        if (arst_n_i === 1'b1 && bus_rsp_o.ack !== stb_seen) begin
            errors++;
            $display("mismatch at %0t: bus_rsp_o.ack got %0b expected %0b",
                     $time, bus_rsp_o.ack, stb_seen);
        end
        stb_seen = bus_req_i.stb;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic next_cycle();
        @(posedge clock_b);
        #1;  // Drive point, 1 ns after the edge
    endtask

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic bus_access(input logic we, input logic [2:0] addr,
                              input logic [7:0] data, output logic [7:0] rdata);
        int waited;
        waited = 0;
        bus_req_i = '{stb: 1'b1, we: we, adr: addr, wdata: data};
        next_cycle();
        bus_req_i = '0;  // Single-cycle strobe
        while (!bus_rsp_o.ack && waited < 4) begin
            next_cycle();
            waited++;
        end
        if (!bus_rsp_o.ack) begin
            errors++;
            $display("no ack from the host bus at %0t, address %0d", $time, addr);
        end
        rdata = bus_rsp_o.rdata;  // Stable here, ack cycle
    endtask

    task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
        bus_access(1'b0, addr, 8'h00, data);
    endtask

    task automatic read_expect(input logic [2:0] addr, input logic [7:0] exp, input string name);
        logic [7:0] got;
        bus_read(addr, got);
        check_val({"bus_rsp_o.rdata @", name}, 16'(got), 16'(exp));
    endtask

    // CTRL write also clears the sticky FIFO flags
    task automatic set_ctrl(input logic [7:0] data);
        bus_write(CTRL, data);
        m_cap   = data[3];
        m_fake  = data[2];
        m_acq   = data[1];
        m_cor   = data[0];
        exp_ovf = 1'b0;
        exp_unf = 1'b0;
    endtask

    function automatic logic [7:0] exp_status();
        return {exp_ovf, exp_unf, (fifo_m.size() == 0), exp_ready, exp_blk};
    endfunction

    // Taps 16 14 13 11 sit at bits 0 2 3 5 of a right-shifting register
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[0] ^ s[2] ^ s[3] ^ s[5];
        return {fb, s[15:1]};
    endfunction

    task automatic model_sample(input logic [N-1:0] live);
        logic [N-1:0] word;
        int p;
        if (m_cap) begin
            word = m_fake ? lfsr_m[N-1:0] : live;  // Bits taken before the step
            if (m_fake) lfsr_m = lfsr_next(lfsr_m);
            if (m_cor) begin
                p = 0;
                for (int i = 0; i < N; i++) begin
                    for (int j = i + 1; j < N; j++) begin
                        if (word[i] == word[j]) pair_acc[p]++;
                        p++;  // (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
                    end
                end
                blk_smp++;
                if (blk_smp == BLK) begin
                    for (int k = 0; k < NUM_PAIRS; k++) begin
                        exp_bank[k] = 16'(pair_acc[k]);
                        pair_acc[k] = 0;
                    end
                    blk_smp   = 0;
                    exp_blk   = exp_blk + 4'd1;  // Wraps at 16
                    exp_ready = 1'b1;
                end
            end
            if (m_acq) begin
                if (fifo_m.size() < DEPTH) fifo_m.push_back(word);
                else exp_ovf = 1'b1;  // Dropped word
            end
        end
    endtask

    // One strobe, then 0 to 3 idle cycles
    task automatic send_random();
        logic [31:0] r;
        int gap;
        r   = $urandom();
        gap = $urandom_range(3, 0);
        antenna_i    = r[N-1:0];
        sample_stb_i = 1'b1;
        model_sample(r[N-1:0]);
        next_cycle();
        sample_stb_i = 1'b0;
        repeat (gap) next_cycle();
    endtask

    // Poll STATUS until block_ready shows, then compare with the model
    task automatic wait_block();
        logic [7:0] st;
        int polls;
        st    = '0;
        polls = 0;
        while (!st[4] && polls < 8) begin
            bus_read(STATUS, st);
            polls++;
        end
        if (!st[4]) begin
            errors++;
            $display("block_ready never set after %0d STATUS reads at %0t", polls, $time);
        end
        check_val("bus_rsp_o.rdata @STATUS", 16'(st), 16'(exp_status()));
        exp_ready = 1'b0;  // That read cleared it
    endtask

    task automatic check_pairs();
        logic [7:0] lo;
        logic [7:0] hi;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            bus_write(VIS_IDX, 8'(p));
            bus_read(VIS_LO, lo);
            bus_read(VIS_HI, hi);
            check_val($sformatf("bus_rsp_o.rdata @VIS pair %0d", p), {hi, lo}, exp_bank[p]);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int unsigned seed_ret;
        seed_ret     = $urandom(SEED);  // Fixed seed, once
        arst_n_i     = 1'b0;
        antenna_i    = '0;
        sample_stb_i = 1'b0;
        bus_req_i    = '0;
        lfsr_m       = 16'hACE1;
        {m_cap, m_fake, m_acq, m_cor} = 4'b0000;
        for (int k = 0; k < NUM_PAIRS; k++) begin
            pair_acc[k] = 0;
            exp_bank[k] = '0;
        end
        blk_smp   = 0;
        exp_blk   = '0;
        exp_ready = 1'b0;
        exp_ovf   = 1'b0;
        exp_unf   = 1'b0;
        repeat (16) @(posedge clock_b);
        #1;
        arst_n_i = 1'b1;
        next_cycle();

        // Reset values
        read_expect(CTRL, 8'h00, "CTRL");
        read_expect(STATUS, 8'h20, "STATUS");
        read_expect(ACQ_LEVEL, 8'h00, "ACQ_LEVEL");

        // Read-back, read-only and unmapped
        set_ctrl(8'hFA);
        read_expect(CTRL, 8'h0A, "CTRL");  // Only 4 bits held
        bus_write(VIS_IDX, 8'h3D);
        read_expect(VIS_IDX, 8'h05, "VIS_IDX");
        bus_write(STATUS, 8'hFF);
        read_expect(STATUS, exp_status(), "STATUS");
        read_expect(CTRL, 8'h0A, "CTRL");
        bus_write(3'd7, 8'hFF);
        read_expect(3'd7, 8'h00, "unmapped");
        read_expect(CTRL, 8'h0A, "CTRL");
        read_expect(VIS_IDX, 8'h05, "VIS_IDX");

        // Live block
        set_ctrl(8'h09);  // cap_en, cor_en
        repeat (BLK) send_random();
        wait_block();
        check_pairs();
        bus_write(VIS_IDX, 8'd6);
        read_expect(VIS_LO, 8'h00, "VIS_LO idx 6");
        read_expect(STATUS, exp_status(), "STATUS");

        // Fake block
        set_ctrl(8'h0D);  // cap_en, fake_en, cor_en
        repeat (BLK) send_random();
        wait_block();
        check_pairs();

        // Raw acquisition, overfill then drain past empty
        set_ctrl(8'h0A);  // cap_en, acq_en
        repeat (DEPTH + 4) send_random();
        repeat (3) next_cycle();  // Strobe to register within 3 cycles
        read_expect(ACQ_LEVEL, 8'(fifo_m.size()), "ACQ_LEVEL");
        read_expect(STATUS, exp_status(), "STATUS");
        while (fifo_m.size() > 0) begin
            read_expect(ACQ_DATA, 8'(fifo_m.pop_front()), "ACQ_DATA");
        end
        read_expect(ACQ_DATA, 8'h00, "ACQ_DATA empty");
        exp_unf = 1'b1;
        read_expect(STATUS, exp_status(), "STATUS");
        set_ctrl(8'h0A);
        read_expect(STATUS, exp_status(), "STATUS");
        read_expect(ACQ_LEVEL, 8'h00, "ACQ_LEVEL");

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verilog
verilog/tart_pkg.sv
verilog/tart_capture.sv
verilog/tart_correlator.sv
verilog/tart_acquire.sv
verilog/tart_control.sv
verilog/tart_top.sv
tests/tb_tart.sv

// ==== Makefile ====
.PHONY: sim clean

# Build and run; status follows the pass line in the output
sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_tart -o tb_tart_sim
	out="$$(./obj_dir/tb_tart_sim)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
